/* build.f */
+incdir+include
design/husky_pkg.sv
design/capture_if.sv
design/reg_decoder.sv
design/capture_engine.sv
design/sample_buffer.sv
design/readback_mux.sv
design/adc_capture_top.sv
sim/adc_capture_sva.sv
sim/tb_adc_capture.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_adc_capture
FILELIST  := build.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_adc_capture.sv */
`timescale 1ns/1ps
`include "husky_config.svh"

module tb_adc_capture;

   logic        ADC_clk_fb = 1'b0;
   logic        arst_n_i;
   logic [7:0]  reg_addr_i;
   logic        reg_wr_i;
   logic        reg_rd_i;
   logic [7:0]  reg_wdata_i;
   logic [7:0]  reg_rdata_o;
   logic [11:0] adc_data_i;
   logic        trigger_i;
   logic        LED_ARMED_o;
   logic        LED_CAP_o;

   logic [31:0] lfsr_q = 32'd92363;
   logic [11:0] adc_hist[$];  // adc value the dut sampled, one entry per edge
   logic        trig_hist[$]; // trigger level on the same edge
   int          arm_cyc = 1;  // first edge whose rise the armed engine can see
   string       chk_name_q[$];
   logic [7:0]  chk_got_q[$];
   logic [7:0]  chk_exp_q[$];

   always #20 ADC_clk_fb = ~ADC_clk_fb; // 40 ns period

   adc_capture_top u_dut (.*);

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [11:0] rand_bits(input int n);
      logic [11:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q); // one step per bit
         v      = {v[10:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic logic [7:0] clamp_count(input logic [7:0] v);
      return (v == 8'd0 || v > 8'd64) ? 8'd64 : v; // 0 and oversize mean full buffer
   endfunction

   function automatic logic [7:0] status_byte(input logic armed, input logic cap,
                                              input logic done);
      return {5'b0, done, cap, armed};
   endfunction

   // first edge at or after from_cyc with trigger high after low, -1 if none
   function automatic int find_rise(input int from_cyc);
      for (int c = from_cyc; c < trig_hist.size(); c++) begin
         if (trig_hist[c] && !trig_hist[c-1])
            return c;
      end
      return -1;
   endfunction

   // reference byte for sample idx of a capture that started on rise_cyc
   function automatic logic [7:0] ref_byte(input int rise_cyc, input int idx, input logic hi);
      logic [11:0] s;
      s = adc_hist[rise_cyc + idx];
      return hi ? {4'h0, s[11:8]} : s[7:0];
   endfunction

   // adc stream, fresh lfsr word every cycle
   initial begin
      adc_data_i <= '0;
      forever begin
         @(posedge ADC_clk_fb);
         adc_data_i <= rand_bits(12);
      end
   end

   // history log, reads the values the dut samples on this edge
   always @(posedge ADC_clk_fb) begin
      if (reg_wr_i && reg_addr_i == `HUSKY_ADDR_CTRL && reg_wdata_i[1:0] == 2'b01)
         arm_cyc = adc_hist.size() + 1; // state is armed one edge later
      adc_hist.push_back(adc_data_i);
      trig_hist.push_back(trigger_i);
   end

   // compare process
   always @(posedge ADC_clk_fb) begin
      string      name;
      logic [7:0] got;
      logic [7:0] exp;
      while (chk_got_q.size() > 0) begin
         name = chk_name_q.pop_front();
         got  = chk_got_q.pop_front();
         exp  = chk_exp_q.pop_front();
         assert (got === exp) else begin
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
         end
      end
   end

   task automatic expect_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      chk_name_q.push_back(name);
      chk_got_q.push_back(got);
      chk_exp_q.push_back(exp);
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      @(posedge ADC_clk_fb);
      reg_addr_i  <= addr;
      reg_wdata_i <= data;
      reg_wr_i    <= 1'b1;
      @(posedge ADC_clk_fb);
      reg_wr_i <= 1'b0;
      @(posedge ADC_clk_fb); // idle cycle
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
      @(posedge ADC_clk_fb);
      reg_addr_i <= addr;
      reg_rd_i   <= 1'b1;
      @(posedge ADC_clk_fb); // strobe sampled here
      reg_rd_i <= 1'b0;
      @(posedge ADC_clk_fb); // mux registers the byte
      @(negedge ADC_clk_fb);
      data = reg_rdata_o;
   endtask

   task automatic check_reg(input logic [7:0] addr, input logic [7:0] exp, input string what);
      logic [7:0] d;
      read_reg(addr, d);
      expect_byte($sformatf("reg_rdata_o (%s)", what), d, exp);
   endtask

   task automatic check_leds(input logic armed, input logic cap);
      expect_byte("LED_ARMED_o", {7'b0, LED_ARMED_o}, {7'b0, armed});
      expect_byte("LED_CAP_o", {7'b0, LED_CAP_o}, {7'b0, cap});
   endtask

   task automatic raise_trigger(input int low_cycles);
      @(posedge ADC_clk_fb);
      trigger_i <= 1'b0;
      repeat (low_cycles) @(posedge ADC_clk_fb);
      trigger_i <= 1'b1;
   endtask

   // poll status until done, bounded
   task automatic wait_done(input int max_polls);
      logic [7:0] st;
      int         n;
      st = '0;
      n  = 0;
      while (!st[2] && n < max_polls) begin
         read_reg(`HUSKY_ADDR_STATUS, st);
         n++;
      end
      if (!st[2]) begin
         $display("TEST FAILED");
         $fatal(1, "timeout, capture not done after %0d status polls", max_polls);
      end
   endtask

   task automatic locate_rise(output int rise_cyc);
      rise_cyc = find_rise(arm_cyc);
      if (rise_cyc < 0) begin
         $display("TEST FAILED");
         $fatal(1, "no trigger rise after arming found in the history");
      end
   endtask

   task automatic drain_and_check(input int rise_cyc, input int n);
      logic [7:0] d;
      for (int i = 0; i < n; i++) begin
         read_reg(`HUSKY_ADDR_DATA_LO, d);
         expect_byte($sformatf("reg_rdata_o (DATA_LO[%0d])", i), d, ref_byte(rise_cyc, i, 1'b0));
         read_reg(`HUSKY_ADDR_DATA_HI, d); // also steps the read pointer
         expect_byte($sformatf("reg_rdata_o (DATA_HI[%0d])", i), d, ref_byte(rise_cyc, i, 1'b1));
      end
   endtask

   initial begin
      int rise4;
      int rise5;
      int n;
      arst_n_i    <= 1'b0;
      reg_addr_i  <= '0;
      reg_wr_i    <= 1'b0;
      reg_rd_i    <= 1'b0;
      reg_wdata_i <= '0;
      trigger_i   <= 1'b0;
      repeat (3) @(posedge ADC_clk_fb);
      arst_n_i <= 1'b1;

      // reset values
      check_reg(`HUSKY_ADDR_STATUS, status_byte(1'b0, 1'b0, 1'b0), "STATUS after reset");
      check_reg(`HUSKY_ADDR_COUNT, clamp_count(8'd0), "COUNT after reset");
      check_leds(1'b0, 1'b0);

      // count register and clamping
      write_reg(`HUSKY_ADDR_COUNT, 8'd10);
      check_reg(`HUSKY_ADDR_COUNT, clamp_count(8'd10), "COUNT after 10");
      write_reg(`HUSKY_ADDR_COUNT, 8'd0);
      check_reg(`HUSKY_ADDR_COUNT, clamp_count(8'd0), "COUNT after 0");
      write_reg(`HUSKY_ADDR_COUNT, 8'd100);
      check_reg(`HUSKY_ADDR_COUNT, clamp_count(8'd100), "COUNT after 100");

      // armed, trigger held low, nothing may be stored
      write_reg(`HUSKY_ADDR_COUNT, 8'd10);
      write_reg(`HUSKY_ADDR_CTRL, 8'h01);
      repeat (20) @(posedge ADC_clk_fb);
      check_reg(`HUSKY_ADDR_STATUS, status_byte(1'b1, 1'b0, 1'b0), "STATUS armed");
      check_leds(1'b1, 1'b0);

      // rise at a random cycle, 10 samples
      raise_trigger(1 + int'(rand_bits(4)));
      wait_done(40);
      check_reg(`HUSKY_ADDR_STATUS, status_byte(1'b0, 1'b0, 1'b1), "STATUS done");
      check_leds(1'b0, 1'b0);
      locate_rise(rise4);
      drain_and_check(rise4, int'(clamp_count(8'd10)));

      // rearm with trigger already high, capture waits for the next rise
      write_reg(`HUSKY_ADDR_COUNT, 8'd64);
      write_reg(`HUSKY_ADDR_CTRL, 8'h01);
      repeat (8) @(posedge ADC_clk_fb);
      check_reg(`HUSKY_ADDR_STATUS, status_byte(1'b1, 1'b0, 1'b0), "STATUS armed, trigger high");
      check_leds(1'b1, 1'b0);
      raise_trigger(3);
      repeat (4) @(posedge ADC_clk_fb); // rise seen, 64 sample burst running
      @(negedge ADC_clk_fb);
      check_leds(1'b0, 1'b1);
      check_reg(`HUSKY_ADDR_STATUS, status_byte(1'b0, 1'b1, 1'b0), "STATUS capturing");
      wait_done(60);
      locate_rise(rise5);
      drain_and_check(rise5, int'(clamp_count(8'd64)));

      // clear while armed
      write_reg(`HUSKY_ADDR_CTRL, 8'h01);
      check_reg(`HUSKY_ADDR_STATUS, status_byte(1'b1, 1'b0, 1'b0), "STATUS rearmed");
      write_reg(`HUSKY_ADDR_CTRL, 8'h02);
      check_reg(`HUSKY_ADDR_STATUS, status_byte(1'b0, 1'b0, 1'b0), "STATUS after clear");
      check_leds(1'b0, 1'b0);
      raise_trigger(2);
      repeat (80) @(posedge ADC_clk_fb);
      check_reg(`HUSKY_ADDR_STATUS, status_byte(1'b0, 1'b0, 1'b0), "STATUS idle trigger");
      check_leds(1'b0, 1'b0);
      drain_and_check(rise5, 4); // buffer still holds the previous capture

      // let the compare process catch up
      n = 0;
      while (chk_got_q.size() > 0 && n < 10) begin
         @(posedge ADC_clk_fb);
         n++;
      end
      if (chk_got_q.size() == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("TEST FAILED");
         $fatal(1, "compare queue did not drain");
      end
   end

endmodule

/* sim/adc_capture_sva.sv */
`timescale 1ns/1ps
`include "husky_config.svh"

module adc_capture_sva
   import husky_pkg::*;
(
   input logic                    ADC_clk_fb,
   input logic                    arst_n_i,
   input logic                    wr_en_i,
   input logic [`HUSKY_PTR_W-1:0] wr_addr_i,
   input capture_state_e          state_i
);

   logic [7:0] cap_len_q; // cycles spent in capture so far

   always_ff @(posedge ADC_clk_fb or negedge arst_n_i) begin
      if (!arst_n_i)
         cap_len_q <= '0;
      else if (state_i == ST_CAPTURE)
         cap_len_q <= cap_len_q + 8'd1;
      else
         cap_len_q <= '0; // restart on every new capture
   end

   // a burst of buffer writes only follows an armed engine
   wr_after_arm: assert property (
      @(posedge ADC_clk_fb) disable iff (!arst_n_i)
      $rose(wr_en_i) |-> $past(state_i) == ST_ARMED
   ) else $error("buffer writes started without an armed engine");

   // one capture fills at most the whole buffer
   capture_bounded: assert property (
      @(posedge ADC_clk_fb) disable iff (!arst_n_i)
      state_i == ST_CAPTURE |-> cap_len_q < 8'(`HUSKY_BUF_DEPTH)
   ) else $error("ST_CAPTURE lasted longer than the buffer depth");

   first_write_at_zero: assert property (
      @(posedge ADC_clk_fb) disable iff (!arst_n_i)
      wr_en_i && !$past(wr_en_i) |-> wr_addr_i == '0
   ) else $error("first write of a capture not at address 0");

   wr_addr_steps: assert property (
      @(posedge ADC_clk_fb) disable iff (!arst_n_i)
      wr_en_i && $past(wr_en_i) |-> wr_addr_i == $past(wr_addr_i) + 6'd1
   ) else $error("write address did not step by one");

endmodule

bind capture_engine adc_capture_sva u_sva (
   .ADC_clk_fb (ADC_clk_fb),
   .arst_n_i   (arst_n_i),
   .wr_en_i    (wr_en_o),
   .wr_addr_i  (wr_addr_o),
   .state_i    (state_o)
);

/* design/adc_capture_top.sv */
`timescale 1ns/1ps
`include "husky_config.svh"

module adc_capture_top
   import husky_pkg::*;
(
   input  logic                    ADC_clk_fb,
   input  logic                    arst_n_i,
   input  logic [`HUSKY_REG_W-1:0] reg_addr_i,
   input  logic                    reg_wr_i,
   input  logic                    reg_rd_i,
   input  logic [`HUSKY_REG_W-1:0] reg_wdata_i,
   output logic [`HUSKY_REG_W-1:0] reg_rdata_o,
   input  logic [`HUSKY_ADC_W-1:0] adc_data_i,
   input  logic                    trigger_i,
   output logic                    LED_ARMED_o,
   output logic                    LED_CAP_o
);

   capture_if cif (); // decoded ops, decoder -> engine + readback

   logic                    buf_wr_en;
   logic [`HUSKY_PTR_W-1:0] buf_wr_addr;
   logic [`HUSKY_PTR_W-1:0] buf_rd_addr;
   logic [`HUSKY_ADC_W-1:0] buf_wr_data;
   logic [`HUSKY_ADC_W-1:0] buf_rd_data;
   capture_state_e          eng_state;
   logic [`HUSKY_REG_W-1:0] eng_count;

   reg_decoder u_dec (
      .ADC_clk_fb  (ADC_clk_fb),
      .arst_n_i    (arst_n_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wr_i    (reg_wr_i),
      .reg_rd_i    (reg_rd_i),
      .reg_wdata_i (reg_wdata_i),
      .cif         (cif.dec)
   );

   capture_engine u_eng (
      .ADC_clk_fb  (ADC_clk_fb),
      .arst_n_i    (arst_n_i),
      .cif         (cif.eng),
      .adc_data_i  (adc_data_i),
      .trigger_i   (trigger_i),
      .wr_en_o     (buf_wr_en),
      .wr_addr_o   (buf_wr_addr),
      .rd_addr_o   (buf_rd_addr),
      .wr_data_o   (buf_wr_data),
      .state_o     (eng_state),
      .count_o     (eng_count),
      .led_armed_o (LED_ARMED_o), // registered levels straight to pins
      .led_cap_o   (LED_CAP_o)
   );

   sample_buffer u_buf (
      .ADC_clk_fb (ADC_clk_fb),
      .wr_en_i    (buf_wr_en),
      .wr_addr_i  (buf_wr_addr),
      .rd_addr_i  (buf_rd_addr),
      .wr_data_i  (buf_wr_data),
      .rd_data_o  (buf_rd_data)
   );

   readback_mux u_rb (
      .ADC_clk_fb  (ADC_clk_fb),
      .arst_n_i    (arst_n_i),
      .cif         (cif.rb),
      .state_i     (eng_state),
      .count_i     (eng_count),
      .rd_data_i   (buf_rd_data),
      .reg_rdata_o (reg_rdata_o)
   );

endmodule

/* design/readback_mux.sv */
`timescale 1ns/1ps
`include "husky_config.svh"

module readback_mux
   import husky_pkg::*;
(
   input  logic                    ADC_clk_fb,
   input  logic                    arst_n_i,
   capture_if.rb                   cif,
   input  capture_state_e          state_i,
   input  logic [`HUSKY_REG_W-1:0] count_i,
   input  logic [`HUSKY_ADC_W-1:0] rd_data_i,
   output logic [`HUSKY_REG_W-1:0] reg_rdata_o
);

   logic [`HUSKY_REG_W-1:0] status_w;
   logic [`HUSKY_REG_W-1:0] sample_lo_w;
   logic [`HUSKY_REG_W-1:0] sample_hi_w;
   logic [`HUSKY_REG_W-1:0] rdata_q;

   // one hot status bits from the engine state
   assign status_w = {
      5'b0,
      state_i == ST_DONE,    // bit 2
      state_i == ST_CAPTURE, // bit 1
      state_i == ST_ARMED    // bit 0
   };

   assign sample_lo_w = rd_data_i[7:0];
   assign sample_hi_w = {4'b0, rd_data_i[`HUSKY_ADC_W-1:8]}; // upper nibble zero

   always_ff @(posedge ADC_clk_fb or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rdata_q <= '0;
      end else begin
         case (cif.op)
            OP_RD_STATUS: rdata_q <= status_w;
            OP_RD_COUNT:  rdata_q <= count_i;
            OP_RD_LO:     rdata_q <= sample_lo_w;
            OP_RD_HI:     rdata_q <= sample_hi_w;
            default:      rdata_q <= rdata_q; // hold until next read
         endcase
      end
   end

   assign reg_rdata_o = rdata_q;

endmodule

/* design/sample_buffer.sv */
`timescale 1ns/1ps
`include "husky_config.svh"

module sample_buffer (
   input  logic                    ADC_clk_fb,
   input  logic                    wr_en_i,
   input  logic [`HUSKY_PTR_W-1:0] wr_addr_i,
   input  logic [`HUSKY_PTR_W-1:0] rd_addr_i,
   input  logic [`HUSKY_ADC_W-1:0] wr_data_i,
   output logic [`HUSKY_ADC_W-1:0] rd_data_o
);

   // 64 x 12, maps onto block or distributed ram
   logic [`HUSKY_ADC_W-1:0] mem [0:`HUSKY_BUF_DEPTH-1];

   // single write port
   always_ff @(posedge ADC_clk_fb) begin
      if (wr_en_i)
         mem[wr_addr_i] <= wr_data_i;
   end

   // registered read, one edge behind rd_addr_i
   always_ff @(posedge ADC_clk_fb) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

/* design/capture_engine.sv */
`timescale 1ns/1ps
`include "husky_config.svh"

module capture_engine
   import husky_pkg::*;
(
   input  logic                    ADC_clk_fb,
   input  logic                    arst_n_i,
   capture_if.eng                  cif,
   input  logic [`HUSKY_ADC_W-1:0] adc_data_i,
   input  logic                    trigger_i,
   output logic                    wr_en_o,
   output logic [`HUSKY_PTR_W-1:0] wr_addr_o,
   output logic [`HUSKY_PTR_W-1:0] rd_addr_o,
   output logic [`HUSKY_ADC_W-1:0] wr_data_o,
   output capture_state_e          state_o,
   output logic [`HUSKY_REG_W-1:0] count_o,
   output logic                    led_armed_o,
   output logic                    led_cap_o
);

   localparam logic [`HUSKY_REG_W-1:0] FULL_CNT = `HUSKY_BUF_DEPTH;

   capture_state_e          state_q, state_d;
   logic                    trig_q, trig_d1;  // registered trigger + its history
   logic [`HUSKY_ADC_W-1:0] data_q;           // aligned with trig_q
   logic [`HUSKY_ADC_W-1:0] cap_data_q;       // sample headed for the buffer
   logic [`HUSKY_CNT_W-1:0] samp_cnt_q;
   logic [`HUSKY_CNT_W-1:0] samp_next;
   logic [`HUSKY_REG_W-1:0] count_q;
   logic [`HUSKY_PTR_W-1:0] rd_ptr_q;
   logic                    rise;
   logic                    last;
   logic                    arm_go;

   assign rise      = trig_q && !trig_d1;
   assign samp_next = samp_cnt_q + 1'b1;
   assign last      = {1'b0, samp_next} >= count_q; // compare at 8 bits
   // arm only honoured from idle or done, clear wins
   assign arm_go    = cif.arm_bit && !cif.clear_bit &&
                      (state_q == ST_IDLE || state_q == ST_DONE);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:    if (cif.arm_bit) state_d = ST_ARMED;
         ST_ARMED:   if (rise) state_d = ST_CAPTURE; // rise sample is #0
         ST_CAPTURE: if (last) state_d = ST_DONE;    // last write this cycle
         ST_DONE:    if (cif.arm_bit) state_d = ST_ARMED;
         default:    state_d = ST_IDLE;
      endcase
      if (cif.clear_bit)
         state_d = ST_IDLE;
   end

   always_ff @(posedge ADC_clk_fb or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q     <= ST_IDLE;
         trig_q      <= 1'b0;
         trig_d1     <= 1'b0;
         samp_cnt_q  <= '0;
         count_q     <= FULL_CNT;
         rd_ptr_q    <= '0;
         led_armed_o <= 1'b0;
         led_cap_o   <= 1'b0;
      end else begin
         state_q     <= state_d;
         trig_q      <= trigger_i;
         trig_d1     <= trig_q;
         led_armed_o <= (state_d == ST_ARMED);
         led_cap_o   <= (state_d == ST_CAPTURE);
         if (arm_go)
            samp_cnt_q <= '0;
         else if (state_q == ST_CAPTURE)
            samp_cnt_q <= samp_next; // one sample per cycle
         if (cif.op == OP_WR_COUNT) begin
            // 0 and anything past the buffer mean a full buffer
            if (cif.wdata == '0 || cif.wdata > FULL_CNT)
               count_q <= FULL_CNT;
            else
               count_q <= cif.wdata;
         end
         if (arm_go)
            rd_ptr_q <= '0;
         else if (cif.op == OP_RD_HI)
            rd_ptr_q <= rd_ptr_q + 1'b1; // hi byte ends a sample
      end
   end

   // sample path, no reset needed
   always_ff @(posedge ADC_clk_fb) begin
      data_q     <= adc_data_i;
      cap_data_q <= data_q;
   end

   assign wr_en_o   = (state_q == ST_CAPTURE);
   assign wr_addr_o = samp_cnt_q[`HUSKY_PTR_W-1:0];
   assign wr_data_o = cap_data_q;
   assign rd_addr_o = rd_ptr_q;
   assign state_o   = state_q;
   assign count_o   = count_q;

endmodule

/* design/reg_decoder.sv */
`timescale 1ns/1ps
`include "husky_config.svh"

module reg_decoder
   import husky_pkg::*;
(
   input  logic                    ADC_clk_fb,
   input  logic                    arst_n_i,
   input  logic [`HUSKY_REG_W-1:0] reg_addr_i,
   input  logic                    reg_wr_i,
   input  logic                    reg_rd_i,
   input  logic [`HUSKY_REG_W-1:0] reg_wdata_i,
   capture_if.dec                  cif
);

   reg_op_e                 op_d;
   reg_op_e                 op_q;
   logic                    arm_q;
   logic                    clear_q;
   logic [`HUSKY_REG_W-1:0] wdata_q;

   // address + direction -> opcode, unmapped gives none
   always_comb begin
      op_d = OP_NONE;
      if (reg_wr_i) begin
         case (reg_addr_i)
            `HUSKY_ADDR_CTRL:  op_d = OP_WR_CTRL;
            `HUSKY_ADDR_COUNT: op_d = OP_WR_COUNT;
            default:           op_d = OP_NONE; // status/data are read only
         endcase
      end else if (reg_rd_i) begin
         case (reg_addr_i)
            `HUSKY_ADDR_STATUS:  op_d = OP_RD_STATUS;
            `HUSKY_ADDR_COUNT:   op_d = OP_RD_COUNT;
            `HUSKY_ADDR_DATA_LO: op_d = OP_RD_LO;
            `HUSKY_ADDR_DATA_HI: op_d = OP_RD_HI;
            default:             op_d = OP_NONE;
         endcase
      end
   end

   always_ff @(posedge ADC_clk_fb or negedge arst_n_i) begin
      if (!arst_n_i) begin
         op_q    <= OP_NONE;
         arm_q   <= 1'b0;
         clear_q <= 1'b0;
      end else begin
         op_q    <= op_d; // returns to none after one cycle
         arm_q   <= (op_d == OP_WR_CTRL) && reg_wdata_i[0];
         clear_q <= (op_d == OP_WR_CTRL) && reg_wdata_i[1];
      end
   end

   // write byte, only meaningful alongside a write op
   always_ff @(posedge ADC_clk_fb) begin
      if (reg_wr_i)
         wdata_q <= reg_wdata_i;
   end

   assign cif.op        = op_q;
   assign cif.wdata     = wdata_q;
   assign cif.arm_bit   = arm_q;
   assign cif.clear_bit = clear_q;

endmodule

/* design/capture_if.sv */
`timescale 1ns/1ps
`include "husky_config.svh"

interface capture_if
   import husky_pkg::*;
();

   reg_op_e                  op;        // single cycle pulse per access
   logic [`HUSKY_REG_W-1:0]  wdata;     // last written byte
   logic                     arm_bit;   // ctrl write with bit 0
   logic                     clear_bit; // ctrl write with bit 1

   // decoder drives everything
   modport dec (
      output op,
      output wdata,
      output arm_bit,
      output clear_bit
   );

   // engine needs the write side too
   modport eng (
      input op,
      input wdata,
      input arm_bit,
      input clear_bit
   );

   // readback only cares which read is pending
   modport rb (
      input op
   );

endinterface

/* design/husky_pkg.sv */
package husky_pkg;

   // capture engine states
   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_ARMED   = 2'd1, // waiting for trigger rise
      ST_CAPTURE = 2'd2,
      ST_DONE    = 2'd3  // buffer holds count samples
   } capture_state_e;

   // decoded bus operations, one per access
   typedef enum logic [2:0] {
      OP_NONE      = 3'd0,
      OP_WR_CTRL   = 3'd1,
      OP_WR_COUNT  = 3'd2,
      OP_RD_STATUS = 3'd3,
      OP_RD_COUNT  = 3'd4,
      OP_RD_LO     = 3'd5, // sample bits 7:0
      OP_RD_HI     = 3'd6  // sample bits 11:8
   } reg_op_e;

endpackage

/* include/husky_config.svh */
`ifndef HUSKY_CONFIG_SVH
`define HUSKY_CONFIG_SVH

// sample buffer geometry
`define HUSKY_BUF_DEPTH 64
`define HUSKY_PTR_W     6
`define HUSKY_CNT_W     7 // holds 0..64

// datapath widths
`define HUSKY_ADC_W     12
`define HUSKY_REG_W     8

// register map, byte addresses on the host bus
`define HUSKY_ADDR_CTRL    8'h00 // wr: bit0 arm, bit1 clear
`define HUSKY_ADDR_COUNT   8'h01 // rd/wr sample count
`define HUSKY_ADDR_STATUS  8'h02 // rd: armed, capturing, done
`define HUSKY_ADDR_DATA_LO 8'h03
`define HUSKY_ADDR_DATA_HI 8'h04 // read of hi byte steps the pointer

`endif
